// ==== Bender.yml ====
package:
  name: issueAlloc

sources:
  - popcntPkg.sv
  - popcntLeaf.sv
  - popcntTree.sv
  - slotPicker.sv
  - issueQueueAlloc.sv
  - allocTop.sv
  - target: simulation
    files:
      - allocTb.sv

// ==== allocGolden.txt ====
// op valid lanes release | expected ready grant freeCountOh freeAtLeast (all hex)
// op 0 is nop, 1 is dispatch, 2 is flush; one line per clock cycle
0 1 0 0000 1 0000 10000 FFFF
1 1 1 0000 1 0001 10000 FFFF
1 1 3 0000 1 0006 08000 7FFF
1 1 7 0000 1 0038 02000 1FFF
0 1 0 0000 1 0000 00400 03FF
1 1 7 0000 1 01C0 00400 03FF
1 1 7 0000 1 0E00 00080 007F
1 1 5 0000 1 3000 00010 000F
1 1 7 0000 0 0000 00004 0003
1 1 7 0000 0 0000 00004 0003
1 1 7 0010 0 0000 00004 0003
1 1 7 0000 1 C010 00008 0007
0 1 0 0000 1 0000 00001 0000
1 1 1 0003 0 0000 00001 0000
1 1 1 0000 1 0001 00004 0003
0 0 0 0002 1 0000 00002 0001
0 1 0 0000 1 0000 00002 0001
1 1 1 00F0 1 0002 00002 0001
1 1 6 0000 1 0030 00010 000F
1 0 1 0000 1 0000 00004 0003
2 1 0 0000 1 0000 00004 0003
0 1 0 0000 1 0000 10000 FFFF
1 1 7 0000 1 0007 10000 FFFF
0 1 0 0000 1 0000 02000 1FFF

// ==== allocTb.sv ====
/*
  Self-checking testbench of the issue-queue slot allocator.
  Replays allocGolden.txt one line per cycle and compares every output with it.
*/

module allocTb;

  localparam int QueueDepth    = popcntPkg::QueueDepth;
  localparam int LaneWidth     = popcntPkg::DispatchWidth;
  localparam int ClockPeriod   = 20;
  localparam int ResetCycles   = 16;
  localparam int TimeoutMargin = 20;
  localparam int WordsPerLine  = 8;
  localparam int MaxLines      = 64;
  localparam int MaxWords      = WordsPerLine * MaxLines;

  logic                  clk;
  logic                  rstN;
  logic                  reqValid;
  popcntPkg::allocOpE    reqOp;
  logic [LaneWidth-1:0]  reqLanes;
  logic                  reqReady;
  logic [QueueDepth-1:0] grantMask;
  logic [QueueDepth-1:0] releaseMask;
  logic [QueueDepth:0]   freeCountOh;
  logic [QueueDepth:1]   freeAtLeast;

  // real data never sets the top three bits, so unused words are easy to spot.
  logic [19:0] golden [0:MaxWords-1];

  int numLines;
  int lineNo;
  int cycleCount;
  int cycleLimit = MaxLines + ResetCycles + TimeoutMargin;

  allocTop #(.QueueDepth(QueueDepth)) dut_i
  (
    .clk         (clk),
    .rstN        (rstN),
    .reqValid    (reqValid),
    .reqOp       (reqOp),
    .reqLanes    (reqLanes),
    .reqReady    (reqReady),
    .grantMask   (grantMask),
    .releaseMask (releaseMask),
    .freeCountOh (freeCountOh),
    .freeAtLeast (freeAtLeast)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(ClockPeriod / 2) clk = ~clk;
  end

  initial
  begin
    cycleCount = 0;
    forever
    begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount >= cycleLimit)
      begin
        $display("timeout: the run went past its limit of %0d cycles", cycleLimit);
        $display("Simulation FAILED");
        $fatal(1);
      end
    end
  end

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %s on golden line %0d: expected 0x%h, got 0x%h",
               name, lineNo, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkMask(input string name, input logic [QueueDepth-1:0] expected,
                           input logic [QueueDepth-1:0] actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %s on golden line %0d: expected 0x%h, got 0x%h",
               name, lineNo, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkCount(input string name, input logic [QueueDepth:0] expected,
                            input logic [QueueDepth:0] actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %s on golden line %0d: expected 0x%h, got 0x%h",
               name, lineNo, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // a count of k free slots means thresholds 1 to k are all reached.
  function automatic logic [QueueDepth:0] countToThermometer(input logic [QueueDepth:0] countOh);
    logic [QueueDepth:0] thermo;
    thermo = '0;
    for (int k = 0; k <= QueueDepth; k++)
    begin
      if (countOh[k])
        thermo = ({{QueueDepth{1'b0}}, 1'b1} << k) - 1'b1;
    end
    return thermo;
  endfunction

  initial
  begin
    int base;
    rstN        = 1'b0;
    reqValid    = 1'b0;
    reqOp       = popcntPkg::opNop;
    reqLanes    = '0;
    releaseMask = '0;
    lineNo      = 0;

    for (int i = 0; i < MaxWords; i++)
      golden[i] = {3'b111, 17'(i)};
    $readmemh("allocGolden.txt", golden);

    numLines = 0;
    while (numLines < MaxLines && golden[numLines * WordsPerLine][19:17] != 3'b111)
      numLines++;
    if (numLines == 0)
    begin
      $display("the golden file holds no test lines");
      $display("Simulation FAILED");
      $fatal(1);
    end
    if (golden[numLines * WordsPerLine - 1][19:17] == 3'b111)
    begin
      $display("the last line of the golden file is incomplete");
      $display("Simulation FAILED");
      $fatal(1);
    end
    cycleLimit = numLines + ResetCycles + TimeoutMargin;

    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    for (lineNo = 1; lineNo <= numLines; lineNo++)
    begin
      @(negedge clk);
      base        = (lineNo - 1) * WordsPerLine;
      reqOp       = popcntPkg::allocOpE'(golden[base][1:0]);
      reqValid    = golden[base + 1][0];
      reqLanes    = golden[base + 2][LaneWidth-1:0];
      releaseMask = golden[base + 3][QueueDepth-1:0];
      #(ClockPeriod / 4); // outputs have settled well before the next rising edge.

      // the two free-slot counters must agree with each other before either meets the file.
      if (!$onehot(freeCountOh))
      begin
        $display("freeCountOh is not one-hot on golden line %0d", lineNo);
        $display("Simulation FAILED");
        $fatal(1);
      end
      checkCount("freeAtLeast against freeCountOh", countToThermometer(freeCountOh),
                 {1'b0, freeAtLeast});

      checkBit("reqReady", golden[base + 4][0], reqReady);
      checkMask("grantMask", golden[base + 5][QueueDepth-1:0], grantMask);
      checkCount("freeCountOh", golden[base + 6][QueueDepth:0], freeCountOh);
      checkCount("freeAtLeast", {1'b0, golden[base + 7][QueueDepth-1:0]}, {1'b0, freeAtLeast});
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== allocTop.sv ====
/*
  Top level of the issue-queue slot allocator.
  Connects the lane counter, the free-slot counters, the picker and the bitmap.
*/

module allocTop
#(
  parameter int QueueDepth = popcntPkg::QueueDepth
)
(
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                reqValid,
  input  popcntPkg::allocOpE                  reqOp,
  input  logic [popcntPkg::DispatchWidth-1:0] reqLanes,
  output logic                                reqReady,
  output logic [QueueDepth-1:0]               grantMask,
  input  logic [QueueDepth-1:0]               releaseMask,
  output logic [QueueDepth:0]                 freeCountOh,
  output logic [QueueDepth:1]                 freeAtLeast
);

  logic [popcntPkg::DispatchWidth:0] laneCountOh;
  logic [QueueDepth-1:0]             freeMask;
  logic [QueueDepth-1:0]             pickMask;

  popcnt3 laneCount_i (.bits(reqLanes), .cnt(laneCountOh));

  // both free-slot counters look at the registered bitmap.
  popcnt16       freeCount_i   (.bits(freeMask), .cnt(freeCountOh));
  popcnt16OrMore freeAtLeast_i (.bits(freeMask), .cnt(freeAtLeast));

  slotPicker #(.QueueDepth(QueueDepth)) picker_i
  (
    .freeMask  (freeMask),
    .laneCount (laneCountOh),
    .pickMask  (pickMask)
  );

  issueQueueAlloc #(.QueueDepth(QueueDepth)) alloc_i
  (
    .clk         (clk),
    .rstN        (rstN),
    .reqValid    (reqValid),
    .reqOp       (reqOp),
    .freeCountOh (freeCountOh),
    .freeAtLeast (freeAtLeast),
    .laneCountOh (laneCountOh),
    .pickMask    (pickMask),
    .releaseMask (releaseMask),
    .reqReady    (reqReady),
    .grantMask   (grantMask),
    .freeMask    (freeMask)
  );

endmodule

// ==== issueAlloc.f ====
popcntPkg.sv
popcntLeaf.sv
popcntTree.sv
slotPicker.sv
issueQueueAlloc.sv
allocTop.sv
allocTb.sv

// ==== issueQueueAlloc.sv ====
/*
  Occupancy bitmap and acceptance logic of the issue-queue slot allocator.
  Grants are combinational; the bitmap follows on the next rising edge.
*/

module issueQueueAlloc
#(
  parameter int QueueDepth = popcntPkg::QueueDepth
)
(
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              reqValid,
  input  popcntPkg::allocOpE                reqOp,
  input  logic [QueueDepth:0]               freeCountOh,
  input  logic [QueueDepth:1]               freeAtLeast,
  input  logic [popcntPkg::DispatchWidth:0] laneCountOh,
  input  logic [QueueDepth-1:0]             pickMask,
  input  logic [QueueDepth-1:0]             releaseMask,
  output logic                              reqReady,
  output logic [QueueDepth-1:0]             grantMask,
  output logic [QueueDepth-1:0]             freeMask
);

  logic [QueueDepth-1:0] occupied;
  logic                  isDispatch;
  logic                  isFlush;
  logic                  groupFits;
  logic                  accept;

  assign isDispatch = (reqOp == popcntPkg::opDispatch);
  assign isFlush    = (reqOp == popcntPkg::opFlush);

  // the thermometer bit at the one-hot lane count tells whether enough slots are free.
  // a full queue can only take an empty group.
  assign groupFits = laneCountOh[0] |
                     (~freeCountOh[0] &
                      (|(laneCountOh[popcntPkg::DispatchWidth:1] &
                         freeAtLeast[popcntPkg::DispatchWidth:1])));

  assign reqReady = ~isDispatch | groupFits; // nop and flush are always taken.
  assign accept   = reqValid & reqReady;

  assign grantMask = (accept && isDispatch) ? pickMask : '0;

  always_ff @(posedge clk)
  begin
    if (!rstN)
      occupied <= '0;
    else if (accept && isFlush)
      occupied <= '0;
    else
      occupied <= (occupied | grantMask) & ~releaseMask;
  end

  assign freeMask = ~occupied; // feeds the counters and the picker.

endmodule

// ==== popcntLeaf.sv ====
/*
  Table-driven population counters that form the leaves of the counter trees.
  Results are one-hot counts, or thermometers for the "or more" variant.
*/

module popcnt3
(
  input  logic [2:0] bits,
  output logic [3:0] cnt
);

  always_comb
  begin
    case (bits)
      3'b000: cnt = 4'b0001;
      3'b001, 3'b010, 3'b100: cnt = 4'b0010;
      3'b011, 3'b101, 3'b110: cnt = 4'b0100;
      3'b111: cnt = 4'b1000;
    endcase
  end

endmodule

module popcnt5
(
  input  logic [4:0] bits,
  output logic [5:0] cnt
);

  always_comb
  begin
    case (bits)
      5'b00000: cnt = 6'b000001;
      5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b10000:
        cnt = 6'b000010;
      5'b00011, 5'b00101, 5'b00110, 5'b01001, 5'b01010,
      5'b01100, 5'b10001, 5'b10010, 5'b10100, 5'b11000:
        cnt = 6'b000100;
      5'b00111, 5'b01011, 5'b01101, 5'b01110, 5'b10011,
      5'b10101, 5'b10110, 5'b11001, 5'b11010, 5'b11100:
        cnt = 6'b001000;
      5'b01111, 5'b10111, 5'b11011, 5'b11101, 5'b11110:
        cnt = 6'b010000;
      5'b11111: cnt = 6'b100000;
    endcase
  end

endmodule

module popcnt6
(
  input  logic [5:0] bits,
  output logic [6:0] cnt
);

  // patterns are grouped by the number of set bits.
  always_comb
  begin
    case (bits)
      6'b000000: cnt = 7'b0000001;
      6'b000001, 6'b000010, 6'b000100, 6'b001000, 6'b010000, 6'b100000:
        cnt = 7'b0000010;
      6'b000011, 6'b000101, 6'b000110, 6'b001001, 6'b001010,
      6'b001100, 6'b010001, 6'b010010, 6'b010100, 6'b011000,
      6'b100001, 6'b100010, 6'b100100, 6'b101000, 6'b110000:
        cnt = 7'b0000100;
      6'b000111, 6'b001011, 6'b001101, 6'b001110, 6'b010011,
      6'b010101, 6'b010110, 6'b011001, 6'b011010, 6'b011100,
      6'b100011, 6'b100101, 6'b100110, 6'b101001, 6'b101010,
      6'b101100, 6'b110001, 6'b110010, 6'b110100, 6'b111000:
        cnt = 7'b0001000;
      6'b001111, 6'b010111, 6'b011011, 6'b011101, 6'b011110,
      6'b100111, 6'b101011, 6'b101101, 6'b101110, 6'b110011,
      6'b110101, 6'b110110, 6'b111001, 6'b111010, 6'b111100:
        cnt = 7'b0010000;
      6'b011111, 6'b101111, 6'b110111, 6'b111011, 6'b111101, 6'b111110:
        cnt = 7'b0100000;
      6'b111111: cnt = 7'b1000000;
    endcase
  end

endmodule

module popcnt5OrMore
(
  input  logic [4:0] bits,
  output logic [5:1] cnt
);

  // bit k of the result is set when at least k inputs are set.
  always_comb
  begin
    case (bits)
      5'b00000: cnt = 5'b00000;
      5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b10000:
        cnt = 5'b00001;
      5'b00011, 5'b00101, 5'b00110, 5'b01001, 5'b01010,
      5'b01100, 5'b10001, 5'b10010, 5'b10100, 5'b11000:
        cnt = 5'b00011;
      5'b00111, 5'b01011, 5'b01101, 5'b01110, 5'b10011,
      5'b10101, 5'b10110, 5'b11001, 5'b11010, 5'b11100:
        cnt = 5'b00111;
      5'b01111, 5'b10111, 5'b11011, 5'b11101, 5'b11110:
        cnt = 5'b01111;
      5'b11111: cnt = 5'b11111;
    endcase
  end

endmodule

// ==== popcntPkg.sv ====
/*
  Shared constants and the command type of the issue-queue slot allocator.
  Modules refer to these through scoped names.
*/

package popcntPkg;

  // number of issue-queue slots tracked by the occupancy bitmap.
  localparam int QueueDepth = 16;

  // widest dispatch group, one slot per lane.
  localparam int DispatchWidth = 3;

  // command carried with every request.
  typedef enum logic [1:0]
  {
    opNop      = 2'b00,
    opDispatch = 2'b01,
    opFlush    = 2'b10
  } allocOpE;

endpackage

// ==== popcntTree.sv ====
/*
  Wider population counters composed from the leaf tables.
  The low half's one-hot count steers a shifted copy of the high half's result.
*/

module popcnt10
(
  input  logic [9:0]  bits,
  output logic [10:0] cnt
);

  logic [5:0] cntA;
  logic [5:0] cntB;

  popcnt5 cntA_i (.bits(bits[4:0]), .cnt(cntA));
  popcnt5 cntB_i (.bits(bits[9:5]), .cnt(cntB));

  // exactly one term survives since cntA is one-hot.
  always_comb
  begin
    cnt = '0;
    for (int i = 0; i < 6; i++)
    begin
      if (cntA[i])
        cnt = cnt | (11'(cntB) << i);
    end
  end

endmodule

module popcnt16
(
  input  logic [15:0] bits,
  output logic [16:0] cnt
);

  logic [6:0]  cntA;
  logic [10:0] cntB;

  popcnt6  cntA_i (.bits(bits[5:0]),  .cnt(cntA));
  popcnt10 cntB_i (.bits(bits[15:6]), .cnt(cntB));

  always_comb
  begin
    cnt = '0;
    for (int i = 0; i < 7; i++)
    begin
      if (cntA[i])
        cnt = cnt | (17'(cntB) << i);
    end
  end

endmodule

module popcnt10OrMore
(
  input  logic [9:0]  bits,
  output logic [10:1] cnt
);

  logic [5:0] cntA;
  logic [5:1] cntB;

  popcnt5       cntA_i (.bits(bits[4:0]), .cnt(cntA));
  popcnt5OrMore cntB_i (.bits(bits[9:5]), .cnt(cntB));

  // the low half already reaches every threshold up to its own count.
  always_comb
  begin
    cnt = '0;
    for (int i = 0; i < 6; i++)
    begin
      if (cntA[i])
        cnt = cnt | (10'(cntB) << i) | ((10'd1 << i) - 10'd1);
    end
  end

endmodule

module popcnt16OrMore
(
  input  logic [15:0] bits,
  output logic [16:1] cnt
);

  logic [6:0]  cntA;
  logic [10:1] cntB;

  popcnt6        cntA_i (.bits(bits[5:0]),  .cnt(cntA));
  popcnt10OrMore cntB_i (.bits(bits[15:6]), .cnt(cntB));

  always_comb
  begin
    cnt = '0;
    for (int i = 0; i < 7; i++)
    begin
      if (cntA[i])
        cnt = cnt | (16'(cntB) << i) | ((16'd1 << i) - 16'd1); // shift, then fill below.
    end
  end

endmodule

// ==== slotPicker.sv ====
/*
  Picks the lowest-indexed free queue slots, one per requested dispatch lane.
  Purely combinational, one find-first-set stage per lane.
*/

module slotPicker
#(
  parameter int QueueDepth = popcntPkg::QueueDepth
)
(
  input  logic [QueueDepth-1:0]              freeMask,
  input  logic [popcntPkg::DispatchWidth:0]  laneCount,
  output logic [QueueDepth-1:0]              pickMask
);

  logic [popcntPkg::DispatchWidth-1:0] needStage;
  logic [QueueDepth-1:0]               remaining;
  logic [QueueDepth-1:0]               lowest;

  // stage s is used when more than s lanes ask for a slot.
  always_comb
  begin
    for (int s = 0; s < popcntPkg::DispatchWidth; s++)
    begin
      needStage[s] = 1'b0;
      for (int k = s + 1; k <= popcntPkg::DispatchWidth; k++)
        needStage[s] = needStage[s] | laneCount[k];
    end
  end

  always_comb
  begin
    remaining = freeMask;
    lowest    = '0;
    pickMask  = '0;
    for (int s = 0; s < popcntPkg::DispatchWidth; s++)
    begin
      lowest = remaining & (~remaining + 1'b1); // isolate the lowest free slot.
      if (needStage[s])
        pickMask = pickMask | lowest;
      remaining = remaining & ~lowest;
    end
  end

endmodule
